/* Makefile */
TOP  = issue_tb
LIST = tomasulo_issue.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module issue -f $(LIST)

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f $(LIST)
	./obj_dir/V$(TOP) | awk '{ print } /^Verification passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* source/cdb_arbiter.sv */
`include "issue_cfg.svh"

module cdb_arbiter (
   input  logic                     mult_valid,
   input  logic [`ISSUE_DATA_W-1:0] mult_data,
   input  logic [`ISSUE_TAG_W-1:0]  mult_tag,
   input  logic                     div_valid,
   input  logic [`ISSUE_DATA_W-1:0] div_data,
   input  logic [`ISSUE_TAG_W-1:0]  div_tag,
   input  logic                     ld_valid,
   input  logic [`ISSUE_DATA_W-1:0] ld_data,
   input  logic [`ISSUE_TAG_W-1:0]  ld_tag,
   input  logic                     int_valid,
   input  logic [`ISSUE_DATA_W-1:0] int_data,
   input  logic [`ISSUE_TAG_W-1:0]  int_tag,
   input  logic                     int_carry,
   input  logic                     int_overflow,
   output logic                     div_grant,
   output logic                     ld_grant,
   output logic                     int_grant,
   output logic                     cdb_valid,
   output logic [`ISSUE_DATA_W-1:0] cdb_data,
   output logic [`ISSUE_TAG_W-1:0]  cdb_tag,
   output logic                     cdb_carry,
   output logic                     cdb_overflow
);

   // The multiplier cannot wait, so it always wins and needs no grant.
   assign div_grant = div_valid && !mult_valid;
   assign ld_grant  = ld_valid && !mult_valid && !div_valid;
   assign int_grant = int_valid && !mult_valid && !div_valid && !ld_valid;

   assign cdb_valid = mult_valid || div_valid || ld_valid || int_valid;

   always_comb begin
      cdb_data = '0;
      cdb_tag  = '0;
      if (mult_valid) begin
         cdb_data = mult_data;
         cdb_tag  = mult_tag;
      end else if (div_grant) begin
         cdb_data = div_data;
         cdb_tag  = div_tag;
      end else if (ld_grant) begin
         cdb_data = ld_data;
         cdb_tag  = ld_tag;
      end else if (int_grant) begin
         cdb_data = int_data;
         cdb_tag  = int_tag;
      end
   end

   // Flags belong to ALU results only.
   assign cdb_carry    = int_grant && int_carry;
   assign cdb_overflow = int_grant && int_overflow;

endmodule

/* source/issue.sv */
`include "issue_cfg.svh"

module issue (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     issue_valid,
   input  issue_pkg::op_e           opcode,
   input  logic [`ISSUE_DATA_W-1:0] rs_data,
   input  logic [`ISSUE_DATA_W-1:0] rt_data,
   input  logic [`ISSUE_TAG_W-1:0]  rd_tag,
   output logic                     busy_int,
   output logic                     busy_mult,
   output logic                     busy_div,
   output logic                     busy_ld_buf,
   output logic                     cdb_valid,
   output logic [`ISSUE_DATA_W-1:0] cdb_data,
   output logic [`ISSUE_TAG_W-1:0]  cdb_tag,
   output logic                     cdb_carry,
   output logic                     cdb_overflow
);

   issue_pkg::unit_e        unit;
   logic                    start_int;
   logic                    start_mult;
   logic                    start_div;
   logic                    start_ld;
   logic                    int_valid;
   logic [`ISSUE_DATA_W-1:0] int_data;
   logic [`ISSUE_TAG_W-1:0]  int_tag;
   logic                    int_carry;
   logic                    int_overflow;
   logic                    int_grant;
   logic                    mult_valid;
   logic [`ISSUE_DATA_W-1:0] mult_data;
   logic [`ISSUE_TAG_W-1:0]  mult_tag;
   logic                    div_valid;
   logic [`ISSUE_DATA_W-1:0] div_data;
   logic [`ISSUE_TAG_W-1:0]  div_tag;
   logic                    div_grant;
   logic                    ld_valid;
   logic [`ISSUE_DATA_W-1:0] ld_data;
   logic [`ISSUE_TAG_W-1:0]  ld_tag;
   logic                    ld_grant;

   always_comb begin
      case (opcode)
         issue_pkg::op_mul, issue_pkg::op_mulh: unit = issue_pkg::unit_mult;
         issue_pkg::op_div, issue_pkg::op_rem:  unit = issue_pkg::unit_div;
         issue_pkg::op_ld, issue_pkg::op_st:    unit = issue_pkg::unit_ld_buf;
         default:                               unit = issue_pkg::unit_int;
      endcase
   end

   assign start_int  = issue_valid && (unit == issue_pkg::unit_int);
   assign start_mult = issue_valid && (unit == issue_pkg::unit_mult);
   assign start_div  = issue_valid && (unit == issue_pkg::unit_div);
   assign start_ld   = issue_valid && (unit == issue_pkg::unit_ld_buf);

   // Products stream through without stalling.
   assign busy_mult = 1'b0;

   issue_int u_int (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start_int),
      .opcode       (opcode),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .rd_tag       (rd_tag),
      .grant        (int_grant),
      .busy         (busy_int),
      .res_valid    (int_valid),
      .res_data     (int_data),
      .res_tag      (int_tag),
      .res_carry    (int_carry),
      .res_overflow (int_overflow)
   );

   issue_mult u_mult (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start_mult),
      .opcode    (opcode),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .rd_tag    (rd_tag),
      .res_valid (mult_valid),
      .res_data  (mult_data),
      .res_tag   (mult_tag)
   );

   issue_div u_div (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start_div),
      .opcode    (opcode),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .rd_tag    (rd_tag),
      .grant     (div_grant),
      .busy      (busy_div),
      .res_valid (div_valid),
      .res_data  (div_data),
      .res_tag   (div_tag)
   );

   issue_ld_buf u_ld_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start_ld),
      .opcode    (opcode),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .rd_tag    (rd_tag),
      .grant     (ld_grant),
      .busy      (busy_ld_buf),
      .res_valid (ld_valid),
      .res_data  (ld_data),
      .res_tag   (ld_tag)
   );

   cdb_arbiter u_arb (
      .mult_valid   (mult_valid),
      .mult_data    (mult_data),
      .mult_tag     (mult_tag),
      .div_valid    (div_valid),
      .div_data     (div_data),
      .div_tag      (div_tag),
      .ld_valid     (ld_valid),
      .ld_data      (ld_data),
      .ld_tag       (ld_tag),
      .int_valid    (int_valid),
      .int_data     (int_data),
      .int_tag      (int_tag),
      .int_carry    (int_carry),
      .int_overflow (int_overflow),
      .div_grant    (div_grant),
      .ld_grant     (ld_grant),
      .int_grant    (int_grant),
      .cdb_valid    (cdb_valid),
      .cdb_data     (cdb_data),
      .cdb_tag      (cdb_tag),
      .cdb_carry    (cdb_carry),
      .cdb_overflow (cdb_overflow)
   );

   // The issuer must respect every busy flag.
   a_issue_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
      !((start_int && busy_int) || (start_div && busy_div) || (start_ld && busy_ld_buf)));

endmodule

/* source/issue_cfg.svh */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// Operand and result width.
`define ISSUE_DATA_W 32

// Destination tag width.
`define ISSUE_TAG_W 6

// Multiplier latency in cycles, at least 2.
`define ISSUE_MULT_STAGES 3

// Load buffer data memory depth in words.
`define ISSUE_DMEM_WORDS 16

`endif

/* source/issue_div.sv */
`include "issue_cfg.svh"

module issue_div (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  issue_pkg::op_e           opcode,
   input  logic [`ISSUE_DATA_W-1:0] rs_data,
   input  logic [`ISSUE_DATA_W-1:0] rt_data,
   input  logic [`ISSUE_TAG_W-1:0]  rd_tag,
   input  logic                     grant,
   output logic                     busy,
   output logic                     res_valid,
   output logic [`ISSUE_DATA_W-1:0] res_data,
   output logic [`ISSUE_TAG_W-1:0]  res_tag
);

   localparam int DW = `ISSUE_DATA_W;
   localparam int CW = $clog2(DW);

   typedef enum logic [1:0] {
      S_IDLE,
      S_RUN,
      S_DONE,
      S_HOLD
   } state_e;

   state_e        state_q;
   logic [CW-1:0] cnt_q;
   logic [DW-1:0] rem_q;
   logic [DW-1:0] quo_q;
   logic [DW-1:0] dvs_q;
   logic          is_rem_q;
   logic [DW:0]   rem_shift;
   logic [DW:0]   trial;

   // Dividend bits shift out of the quotient register into the remainder.
   assign rem_shift = {rem_q, quo_q[DW-1]};
   assign trial     = rem_shift - {1'b0, dvs_q};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= S_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (start) begin
                  state_q <= S_RUN;
                  cnt_q   <= '0;
               end
            end
            S_RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == CW'(DW - 1)) begin
                  state_q <= S_DONE;
               end
            end
            S_DONE: state_q <= S_HOLD;
            S_HOLD: begin
               if (grant) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // A zero divisor never borrows, so the quotient fills with ones
   // and the remainder ends up as the dividend.
   always_ff @(posedge clk) begin
      case (state_q)
         S_IDLE: begin
            if (start) begin
               rem_q    <= '0;
               quo_q    <= rs_data;
               dvs_q    <= rt_data;
               is_rem_q <= opcode == issue_pkg::op_rem;
               res_tag  <= rd_tag;
            end
         end
         S_RUN: begin
            if (!trial[DW]) begin
               rem_q <= trial[DW-1:0];
               quo_q <= {quo_q[DW-2:0], 1'b1};
            end else begin
               rem_q <= rem_shift[DW-1:0];
               quo_q <= {quo_q[DW-2:0], 1'b0};
            end
         end
         S_DONE: res_data <= is_rem_q ? rem_q : quo_q;
         default: ;
      endcase
   end

   assign busy      = state_q != S_IDLE;
   assign res_valid = state_q == S_HOLD;

   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

/* source/issue_int.sv */
`include "issue_cfg.svh"

module issue_int (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  issue_pkg::op_e           opcode,
   input  logic [`ISSUE_DATA_W-1:0] rs_data,
   input  logic [`ISSUE_DATA_W-1:0] rt_data,
   input  logic [`ISSUE_TAG_W-1:0]  rd_tag,
   input  logic                     grant,
   output logic                     busy,
   output logic                     res_valid,
   output logic [`ISSUE_DATA_W-1:0] res_data,
   output logic [`ISSUE_TAG_W-1:0]  res_tag,
   output logic                     res_carry,
   output logic                     res_overflow
);

   localparam int DW = `ISSUE_DATA_W;
   localparam int SW = $clog2(DW);

   logic [DW:0]   sum;
   logic [DW:0]   diff;
   logic [DW-1:0] alu_data;
   logic          alu_carry;
   logic          alu_ovf;

   assign sum  = {1'b0, rs_data} + {1'b0, rt_data};
   assign diff = {1'b0, rs_data} - {1'b0, rt_data};

   always_comb begin
      alu_data  = '0;
      alu_carry = 1'b0;
      alu_ovf   = 1'b0;
      case (opcode)
         issue_pkg::op_add: begin
            alu_data  = sum[DW-1:0];
            alu_carry = sum[DW];
            alu_ovf   = (rs_data[DW-1] == rt_data[DW-1]) && (sum[DW-1] != rs_data[DW-1]);
         end
         issue_pkg::op_sub: begin
            // Carry reports the borrow of the subtraction.
            alu_data  = diff[DW-1:0];
            alu_carry = diff[DW];
            alu_ovf   = (rs_data[DW-1] != rt_data[DW-1]) && (diff[DW-1] != rs_data[DW-1]);
         end
         issue_pkg::op_and: alu_data = rs_data & rt_data;
         issue_pkg::op_or:  alu_data = rs_data | rt_data;
         issue_pkg::op_xor: alu_data = rs_data ^ rt_data;
         issue_pkg::op_slt: alu_data = {{(DW-1){1'b0}}, $signed(rs_data) < $signed(rt_data)};
         issue_pkg::op_sll: alu_data = rs_data << rt_data[SW-1:0];
         issue_pkg::op_srl: alu_data = rs_data >> rt_data[SW-1:0];
         default: alu_data = '0;
      endcase
   end

   // Result stays put until the CDB takes it.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else if (start) begin
         res_valid <= 1'b1;
      end else if (grant) begin
         res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         res_data     <= alu_data;
         res_tag      <= rd_tag;
         res_carry    <= alu_carry;
         res_overflow <= alu_ovf;
      end
   end

   assign busy = res_valid;

endmodule

/* source/issue_ld_buf.sv */
`include "issue_cfg.svh"

module issue_ld_buf (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  issue_pkg::op_e           opcode,
   input  logic [`ISSUE_DATA_W-1:0] rs_data,
   input  logic [`ISSUE_DATA_W-1:0] rt_data,
   input  logic [`ISSUE_TAG_W-1:0]  rd_tag,
   input  logic                     grant,
   output logic                     busy,
   output logic                     res_valid,
   output logic [`ISSUE_DATA_W-1:0] res_data,
   output logic [`ISSUE_TAG_W-1:0]  res_tag
);

   localparam int DW    = `ISSUE_DATA_W;
   localparam int DEPTH = `ISSUE_DMEM_WORDS;
   localparam int AW    = $clog2(DEPTH);

   logic [DW-1:0] mem [DEPTH];
   logic [AW-1:0] addr;
   logic          is_ld;
   logic          is_st;

   // Word address wraps at the memory depth.
   assign addr  = rs_data[AW-1:0];
   assign is_ld = start && (opcode == issue_pkg::op_ld);
   assign is_st = start && (opcode == issue_pkg::op_st);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (is_st) begin
         mem[addr] <= rt_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else if (is_ld) begin
         res_valid <= 1'b1;
      end else if (grant) begin
         res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (is_ld) begin
         res_data <= mem[addr];
         res_tag  <= rd_tag;
      end
   end

   assign busy = res_valid;

endmodule

/* source/issue_mult.sv */
`include "issue_cfg.svh"

module issue_mult (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  issue_pkg::op_e           opcode,
   input  logic [`ISSUE_DATA_W-1:0] rs_data,
   input  logic [`ISSUE_DATA_W-1:0] rt_data,
   input  logic [`ISSUE_TAG_W-1:0]  rd_tag,
   output logic                     res_valid,
   output logic [`ISSUE_DATA_W-1:0] res_data,
   output logic [`ISSUE_TAG_W-1:0]  res_tag
);

   localparam int DW = `ISSUE_DATA_W;
   localparam int HW = DW / 2;
   localparam int S  = `ISSUE_MULT_STAGES;

   logic [S-1:0]            vld_q;
   logic [S-1:0]            hi_q;
   logic [`ISSUE_TAG_W-1:0] tag_q [S];
   logic [DW+HW-1:0]        pp_lo_q;
   logic [DW+HW-1:0]        pp_hi_q;
   logic [2*DW-1:0]         prod_q [1:S-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[S-2:0], start};
      end
   end

   // First stage holds two partial products, the second adds them.
   always_ff @(posedge clk) begin
      hi_q      <= {hi_q[S-2:0], opcode == issue_pkg::op_mulh};
      tag_q[0]  <= rd_tag;
      pp_lo_q   <= (DW+HW)'(rs_data) * (DW+HW)'(rt_data[HW-1:0]);
      pp_hi_q   <= (DW+HW)'(rs_data) * (DW+HW)'(rt_data[DW-1:HW]);
      prod_q[1] <= (2*DW)'(pp_lo_q) + ((2*DW)'(pp_hi_q) << HW);
      for (int i = 1; i < S; i++) begin
         tag_q[i] <= tag_q[i-1];
      end
      for (int i = 2; i < S; i++) begin
         prod_q[i] <= prod_q[i-1];
      end
   end

   assign res_valid = vld_q[S-1];
   assign res_tag   = tag_q[S-1];
   assign res_data  = hi_q[S-1] ? prod_q[S-1][2*DW-1:DW] : prod_q[S-1][DW-1:0];

endmodule

/* source/issue_pkg.sv */
package issue_pkg;

   // Operation codes seen on the issue port.
   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_and  = 4'd2,
      op_or   = 4'd3,
      op_xor  = 4'd4,
      op_slt  = 4'd5,
      op_sll  = 4'd6,
      op_srl  = 4'd7,
      op_mul  = 4'd8,
      op_mulh = 4'd9,
      op_div  = 4'd10,
      op_rem  = 4'd11,
      op_ld   = 4'd12,
      op_st   = 4'd13
   } op_e;

   // Functional unit that executes an operation.
   typedef enum logic [1:0] {
      unit_int    = 2'd0,
      unit_mult   = 2'd1,
      unit_div    = 2'd2,
      unit_ld_buf = 2'd3
   } unit_e;

endpackage

/* tomasulo_issue.f */
+incdir+source
source/issue_pkg.sv
source/issue_int.sv
source/issue_mult.sv
source/issue_div.sv
source/issue_ld_buf.sv
source/cdb_arbiter.sv
source/issue.sv
verification/issue_tb.sv

/* verification/issue_tb.sv */
`include "issue_cfg.svh"

module issue_tb;

   localparam int DW         = `ISSUE_DATA_W;
   localparam int TW         = `ISSUE_TAG_W;
   localparam int SW         = $clog2(DW);
   localparam int NTAGS      = 1 << TW;
   localparam int DEPTH      = `ISSUE_DMEM_WORDS;
   localparam int AW         = $clog2(DEPTH);
   // Roughly twice the length of all phases together.
   localparam int WATCHDOG_T = 20000;

   logic           clk = 1'b0;
   logic           rst_n;
   logic           issue_valid;
   issue_pkg::op_e opcode;
   logic [DW-1:0]  rs_data;
   logic [DW-1:0]  rt_data;
   logic [TW-1:0]  rd_tag;
   logic           busy_int;
   logic           busy_mult;
   logic           busy_div;
   logic           busy_ld_buf;
   logic           cdb_valid;
   logic [DW-1:0]  cdb_data;
   logic [TW-1:0]  cdb_tag;
   logic           cdb_carry;
   logic           cdb_overflow;

   // Reference state, one entry per tag.
   logic [DW-1:0]  exp_data [NTAGS];
   logic           exp_carry [NTAGS];
   logic           exp_ovf [NTAGS];
   logic           is_mult [NTAGS];
   int             due [NTAGS];
   logic           live [NTAGS];
   logic [DW-1:0]  mem_model [DEPTH];
   logic [TW-1:0]  next_tag;
   logic [TW-1:0]  div_tag;
   logic           div_waiting;
   logic           issued_any;
   int             pending;
   int             cyc = 0;

   issue uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .opcode       (opcode),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .rd_tag       (rd_tag),
      .busy_int     (busy_int),
      .busy_mult    (busy_mult),
      .busy_div     (busy_div),
      .busy_ld_buf  (busy_ld_buf),
      .cdb_valid    (cdb_valid),
      .cdb_data     (cdb_data),
      .cdb_tag      (cdb_tag),
      .cdb_carry    (cdb_carry),
      .cdb_overflow (cdb_overflow)
   );

   always #4 clk = ~clk;

   function automatic issue_pkg::unit_e unit_of(input issue_pkg::op_e op);
      case (op)
         issue_pkg::op_mul, issue_pkg::op_mulh: return issue_pkg::unit_mult;
         issue_pkg::op_div, issue_pkg::op_rem:  return issue_pkg::unit_div;
         issue_pkg::op_ld, issue_pkg::op_st:    return issue_pkg::unit_ld_buf;
         default:                               return issue_pkg::unit_int;
      endcase
   endfunction

   function automatic logic unit_busy(input issue_pkg::unit_e u);
      case (u)
         issue_pkg::unit_int:  return busy_int;
         issue_pkg::unit_mult: return busy_mult;
         issue_pkg::unit_div:  return busy_div;
         default:              return busy_ld_buf;
      endcase
   endfunction

   function automatic logic [AW-1:0] word_addr(input logic [DW-1:0] a);
      return AW'(a % DW'(DEPTH));
   endfunction

   function automatic logic [DW-1:0] edge_value(input int i);
      case (i)
         0:       return '1;
         1:       return {1'b1, {(DW-1){1'b0}}};
         2:       return {1'b0, {(DW-1){1'b1}}};
         3:       return '0;
         default: return DW'(1);
      endcase
   endfunction

   function automatic logic [DW-1:0] pick_operand();
      if ($urandom_range(7) < 5) begin
         return edge_value(int'($urandom_range(4)));
      end
      return DW'($urandom);
   endfunction

   // Expected {carry, overflow, data} of one operation.
   function automatic logic [DW+1:0] model_result(input issue_pkg::op_e op,
                                                  input logic [DW-1:0] a,
                                                  input logic [DW-1:0] b);
      longint          smax;
      longint          wide;
      logic [2*DW-1:0] prod;
      logic            c;
      logic            v;
      logic [DW-1:0]   d;
      smax = (longint'(1) <<< (DW - 1)) - 1;
      c    = 1'b0;
      v    = 1'b0;
      prod = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
      case (op)
         issue_pkg::op_add: begin
            d    = a + b;
            c    = (longint'(a) + longint'(b)) > longint'({DW{1'b1}});
            wide = longint'($signed(a)) + longint'($signed(b));
            v    = (wide > smax) || (wide < -smax - 1);
         end
         issue_pkg::op_sub: begin
            d    = a - b;
            c    = a < b;
            wide = longint'($signed(a)) - longint'($signed(b));
            v    = (wide > smax) || (wide < -smax - 1);
         end
         issue_pkg::op_and:  d = a & b;
         issue_pkg::op_or:   d = a | b;
         issue_pkg::op_xor:  d = a ^ b;
         issue_pkg::op_slt:  d = DW'($signed(a) < $signed(b));
         issue_pkg::op_sll:  d = a << b[SW-1:0];
         issue_pkg::op_srl:  d = a >> b[SW-1:0];
         issue_pkg::op_mul:  d = prod[DW-1:0];
         issue_pkg::op_mulh: d = prod[2*DW-1:DW];
         issue_pkg::op_div:  d = (b == '0) ? '1 : a / b;
         issue_pkg::op_rem:  d = (b == '0) ? a : a % b;
         issue_pkg::op_ld:   d = mem_model[word_addr(a)];
         default:            d = '0;
      endcase
      return {c, v, d};
   endfunction

   // Records every accepted issue and retires tags seen on the CDB.
   always @(posedge clk) begin : scoreboard
      logic [DW+1:0] res;
      logic          takes_tag;
      res       = model_result(opcode, rs_data, rt_data);
      takes_tag = issue_valid && (opcode != issue_pkg::op_st);
      cyc <= cyc + 1;
      if (!rst_n) begin
         for (int i = 0; i < NTAGS; i++) begin
            live[i] <= 1'b0;
         end
         for (int i = 0; i < DEPTH; i++) begin
            mem_model[i] <= '0;
         end
         pending     <= 0;
         div_waiting <= 1'b0;
         issued_any  <= 1'b0;
      end else begin
         if (cdb_valid) begin
            live[cdb_tag] <= 1'b0;
            if (cdb_tag == div_tag) begin
               div_waiting <= 1'b0;
            end
         end
         if (issue_valid) begin
            issued_any <= 1'b1;
         end
         if (issue_valid && !takes_tag) begin
            mem_model[word_addr(rs_data)] <= rt_data;
         end
         if (takes_tag) begin
            live[rd_tag]      <= 1'b1;
            exp_data[rd_tag]  <= res[DW-1:0];
            exp_ovf[rd_tag]   <= res[DW];
            exp_carry[rd_tag] <= res[DW+1];
            is_mult[rd_tag]   <= unit_of(opcode) == issue_pkg::unit_mult;
            due[rd_tag]       <= cyc + `ISSUE_MULT_STAGES;
            if (unit_of(opcode) == issue_pkg::unit_div) begin
               div_waiting <= 1'b1;
               div_tag     <= rd_tag;
            end
         end
         pending <= pending + int'(takes_tag) - int'(cdb_valid);
      end
   end

   task automatic report_fail(input string msg);
      $display("Fail at time %0t: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !issued_any |-> !(cdb_valid || busy_int || busy_mult || busy_div || busy_ld_buf))
      else report_fail("CDB or a busy flag active before any issue");
   a_mult_never_busy: assert property (@(posedge clk) disable iff (!rst_n) !busy_mult)
      else report_fail("busy_mult went high");
   a_known_tag: assert property (@(posedge clk) disable iff (!rst_n) cdb_valid |-> live[cdb_tag])
      else report_fail($sformatf("CDB tag %0d is not in flight", $sampled(cdb_tag)));
   a_cdb_data: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> cdb_data == exp_data[cdb_tag])
      else report_fail($sformatf("tag %0d data %h, expected %h", $sampled(cdb_tag),
                                 $sampled(cdb_data), exp_data[$sampled(cdb_tag)]));
   a_cdb_flags: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> cdb_carry == exp_carry[cdb_tag] && cdb_overflow == exp_ovf[cdb_tag])
      else report_fail($sformatf("tag %0d carry/overflow %b%b, expected %b%b",
                                 $sampled(cdb_tag), $sampled(cdb_carry), $sampled(cdb_overflow),
                                 exp_carry[$sampled(cdb_tag)], exp_ovf[$sampled(cdb_tag)]));
   a_mult_latency: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid && is_mult[cdb_tag] |-> cyc == due[cdb_tag])
      else report_fail($sformatf("product tag %0d off its fixed latency", $sampled(cdb_tag)));
   a_div_busy: assert property (@(posedge clk) disable iff (!rst_n) div_waiting |-> busy_div)
      else report_fail("busy_div low while a divide result is outstanding");

   // Waits for the unit to be free, then holds the strobe for one edge.
   task automatic send_op(input issue_pkg::op_e op, input logic [DW-1:0] a,
                          input logic [DW-1:0] b);
      while (unit_busy(unit_of(op))) begin
         issue_valid = 1'b0;
         @(posedge clk);
         #1;
      end
      issue_valid = 1'b1;
      opcode      = op;
      rs_data     = a;
      rt_data     = b;
      rd_tag      = next_tag;
      next_tag    = next_tag + 1'b1;
      @(posedge clk);
      #1;
      issue_valid = 1'b0;
   endtask

   task automatic drain();
      while (pending != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   initial begin
      void'($urandom(32'hb3b912b1));
      rst_n       = 1'b0;
      issue_valid = 1'b0;
      opcode      = issue_pkg::op_add;
      rs_data     = '0;
      rt_data     = '0;
      rd_tag      = '0;
      next_tag    = '0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      // ALU over every pair of edge operands, then random operations.
      for (int op = 0; op < 8; op++) begin
         for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
               send_op(issue_pkg::op_e'(4'(op)), edge_value(i), edge_value(j));
            end
         end
      end
      for (int n = 0; n < 60; n++) begin
         send_op(issue_pkg::op_e'(4'($urandom_range(7))), pick_operand(), pick_operand());
      end
      drain();
      for (int n = 0; n < 24; n++) begin
         send_op($urandom_range(1) ? issue_pkg::op_mulh : issue_pkg::op_mul,
                 pick_operand(), pick_operand());
      end
      drain();
      send_op(issue_pkg::op_div, DW'(100), DW'(7));
      send_op(issue_pkg::op_rem, DW'(100), DW'(7));
      send_op(issue_pkg::op_div, pick_operand(), '0);
      send_op(issue_pkg::op_rem, DW'($urandom), '0);
      for (int n = 0; n < 8; n++) begin
         send_op($urandom_range(1) ? issue_pkg::op_rem : issue_pkg::op_div,
                 DW'($urandom), pick_operand());
      end
      drain();
      // Untouched words read back as zero.
      for (int i = 0; i < DEPTH; i++) begin
         send_op(issue_pkg::op_ld, DW'(i), DW'($urandom));
      end
      for (int n = 0; n < 24; n++) begin
         send_op(issue_pkg::op_st, DW'($urandom), DW'($urandom));
      end
      for (int n = 0; n < 32; n++) begin
         send_op(issue_pkg::op_ld, DW'($urandom), '0);
      end
      drain();
      // Divide, load and ALU results pile up behind a stream of products.
      send_op(issue_pkg::op_div, DW'($urandom), DW'($urandom_range(1000, 1)));
      for (int n = 0; n < 43; n++) begin
         if (n == 30) begin
            send_op(issue_pkg::op_ld, DW'($urandom), '0);
            send_op(issue_pkg::op_add, pick_operand(), pick_operand());
         end
         send_op(issue_pkg::op_mul, DW'($urandom), DW'($urandom));
      end
      drain();
      $display("Verification passed");
      $finish;
   end

   initial begin
      #WATCHDOG_T;
      $display("Watchdog expired before all results came back on the CDB");
      $display("Verification failed");
      $fatal(1, "timeout");
   end

endmodule
